/* src/dcache_pkg.sv */
// data cache address split, FSAB and SPAM constants and bus structs; compile before all RTL
`default_nettype none

package dcache_pkg;

	// 32-bit address is tag 31..10, line 9..6, beat 5..3, word select on bit 2
	localparam int tag_w = 22;
	localparam int idx_w = 4;
	// 8 beats of 64 bits per line
	localparam int word_w = 3;

	// fsab burst lengths in 64-bit beats
	localparam int fsab_len_line = 8;
	localparam int fsab_len_word = 1;

	// cycles a spam transaction may stay busy
	localparam int spam_timeout_init = 255;

	typedef enum logic {
		fsab_read = 1'b0,
		fsab_write = 1'b1
	} fsab_mode_e;

	// stamped on outbound requests, matched on inbound beats
	localparam logic [3:0] fsab_did_cpu = 4'h0;
	localparam logic [3:0] fsab_subdid_dcache = 4'h1;

	typedef struct packed {
		logic valid;
		fsab_mode_e mode;
		logic [3:0] did;
		logic [3:0] subdid;
		logic [30:0] addr;
		logic [3:0] len;
		logic [63:0] data;
		logic [7:0] mask;
	} fsab_req_t;

	// one inbound fill beat
	typedef struct packed {
		logic valid;
		logic [3:0] did;
		logic [3:0] subdid;
		logic [63:0] data;
	} fsab_resp_t;

	typedef struct packed {
		logic valid;
		logic r_nw;
		logic [3:0] did;
		logic [23:0] addr;
		logic [31:0] data;
	} spam_req_t;

	// core load/store port, held until rw_wait drops
	typedef struct packed {
		logic rd;
		logic wr;
		logic [31:0] addr;
		logic [31:0] wdata;
	} core_req_t;

endpackage

`default_nettype wire

/* src/dcache_array.sv */
// data cache storage with valid bits, tags and hi/lo words; core lookup and fill write ports
`timescale 1ns/1ps
`default_nettype none

module dcache_array (
	input wire logic clk,
	input wire logic rst_b,
	input wire logic [31:0] lookup_addr,
	input wire logic core_wr,
	input wire logic [31:0] core_wdata,
	input wire logic [dcache_pkg::idx_w-1:0] fill_idx,
	input wire logic line_set,
	input wire logic line_clr,
	input wire logic [dcache_pkg::tag_w-1:0] fill_tag,
	input wire logic fill_we,
	input wire logic [dcache_pkg::word_w-1:0] fill_word,
	input wire logic [63:0] fill_data,
	output logic hit,
	output logic [31:0] rd_word
);
	localparam int lines = 2 ** dcache_pkg::idx_w;
	localparam int slot_w = dcache_pkg::idx_w + dcache_pkg::word_w;
	localparam int words = 2 ** slot_w;

	logic [lines-1:0] line_valid;
	logic [dcache_pkg::tag_w-1:0] tags [lines];
	logic [31:0] data_hi [words];
	logic [31:0] data_lo [words];

	logic [dcache_pkg::idx_w-1:0] idx;
	logic [dcache_pkg::tag_w-1:0] tag;
	logic [slot_w-1:0] rd_slot;
	logic [slot_w-1:0] fill_slot;

	assign idx = lookup_addr[9:6];
	assign tag = lookup_addr[31 -: dcache_pkg::tag_w];
	// slot is {line, beat}
	assign rd_slot = {idx, lookup_addr[5:3]};
	assign fill_slot = {fill_idx, fill_word};

	// same-cycle lookup
	assign hit = line_valid[idx] && (tags[idx] == tag);
	// bit 2 picks the upper half of the beat
	assign rd_word = lookup_addr[2] ? data_hi[rd_slot] : data_lo[rd_slot];

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			line_valid <= '0;
		end else if (line_clr) begin
			// line goes invalid while it refills
			line_valid[fill_idx] <= 1'b0;
		end else if (line_set) begin
			line_valid[fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (line_set) begin
			tags[fill_idx] <= fill_tag;
		end
	end

	always_ff @(posedge clk) begin
		// write-through copy, only when the line holds this address
		if (core_wr && hit && lookup_addr[2]) begin
			data_hi[rd_slot] <= core_wdata;
		end
		if (core_wr && hit && !lookup_addr[2]) begin
			data_lo[rd_slot] <= core_wdata;
		end
		// fill beat lands both halves
		if (fill_we) begin
			data_hi[fill_slot] <= fill_data[63:32];
			data_lo[fill_slot] <= fill_data[31:0];
		end
	end

endmodule

`default_nettype wire

/* src/dcache_fill.sv */
// FSAB inbound side of the data cache; counts fill beats and hands them to the array
`timescale 1ns/1ps
`default_nettype none

module dcache_fill (
	input wire logic fsabi_clk,
	input wire logic fsabi_rst_b,
	input wire dcache_pkg::fsab_resp_t fsabi,
	input wire logic rd_tog,
	output logic done_tog,
	output logic fill_we,
	output logic [dcache_pkg::word_w-1:0] fill_word,
	output logic [63:0] fill_data
);
	logic rd_s1;
	logic rd_s2;
	logic rd_s3;
	logic restart;
	logic beat_ok;
	logic [dcache_pkg::word_w-1:0] beat_cnt;
	logic [dcache_pkg::word_w-1:0] beat_pos;

	// new read when the synced toggle flips
	assign restart = rd_s2 ^ rd_s3;
	assign beat_ok = fsabi.valid && (fsabi.did == dcache_pkg::fsab_did_cpu) &&
		(fsabi.subdid == dcache_pkg::fsab_subdid_dcache);
	// a beat in the restart cycle is beat 0
	assign beat_pos = restart ? '0 : beat_cnt;

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			rd_s1 <= 1'b0;
			rd_s2 <= 1'b0;
			rd_s3 <= 1'b0;
			done_tog <= 1'b0;
			beat_cnt <= '0;
			fill_we <= 1'b0;
		end else begin
			rd_s1 <= rd_tog;
			rd_s2 <= rd_s1;
			rd_s3 <= rd_s2;
			fill_we <= beat_ok;
			if (beat_ok) begin
				beat_cnt <= beat_pos + 1'b1;
				// last beat, report this read as done
				if (beat_pos == '1) begin
					done_tog <= rd_s2;
				end
			end else if (restart) begin
				beat_cnt <= '0;
			end
		end
	end

	// beat is held for a whole fsabi cycle, longer than a core clock,
	// so the array catches every beat at least once; a repeat is harmless
	always_ff @(posedge fsabi_clk) begin
		if (beat_ok) begin
			fill_word <= beat_pos;
			fill_data <= fsabi.data;
		end
	end

	// beats only come after the read toggle got here
	a_beat_in_fill: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		beat_ok |-> (rd_s2 != done_tog));

endmodule

`default_nettype wire

/* src/spam_initiator.sv */
// SPAM side channel master for uncached accesses; one transaction at a time with timeout
`timescale 1ns/1ps
`default_nettype none

module spam_initiator #(
	parameter int spam_timeout = dcache_pkg::spam_timeout_init
) (
	input wire logic clk,
	input wire logic rst_b,
	input wire dcache_pkg::core_req_t core,
	input wire logic spami_busy_b,
	input wire logic [31:0] spami_data,
	output dcache_pkg::spam_req_t spamo,
	output logic wait_spam,
	output logic [31:0] rd_data_spam
);
	localparam int timer_w = $clog2(spam_timeout + 1);

	logic req;
	logic in_flight;
	logic expired;
	logic finish;
	logic [timer_w-1:0] timer;

	// bit 31 selects the side channel
	assign req = (core.rd || core.wr) && core.addr[31];
	assign expired = (timer == '0);
	// release from the peripheral wins over the timeout
	assign finish = in_flight && (spami_busy_b || expired);

	always_comb begin
		spamo = '0;
		spamo.valid = req && !in_flight;
		spamo.r_nw = core.rd;
		spamo.did = core.addr[27:24];
		spamo.addr = core.addr[23:0];
		spamo.data = core.wdata;
	end

	// core waits through the issue cycle and the busy period
	assign wait_spam = req && !finish;
	assign rd_data_spam = (in_flight && expired && !spami_busy_b) ? 32'hdeaddead : spami_data;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			in_flight <= 1'b0;
			timer <= '0;
		end else if (spamo.valid) begin
			in_flight <= 1'b1;
			timer <= timer_w'(spam_timeout);
		end else if (finish) begin
			in_flight <= 1'b0;
		end else if (in_flight) begin
			timer <= timer - 1'b1;
		end
	end

	// core keeps its access up until the channel lets go
	a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_b)
		in_flight |-> req);

endmodule

`default_nettype wire

/* src/dcache_ctrl.sv */
// core-side data cache control; misses, write-through, FSAB credits and the stall signal
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int init_credits = 4,
	parameter int credit_w = 3
) (
	input wire logic clk,
	input wire logic rst_b,
	input wire dcache_pkg::core_req_t core,
	input wire logic hit,
	input wire logic [31:0] rd_word,
	input wire logic fsabo_credit,
	input wire logic done_tog,
	input wire logic wait_spam,
	input wire logic [31:0] rd_data_spam,
	output dcache_pkg::fsab_req_t fsabo,
	output logic rd_tog,
	output logic [dcache_pkg::idx_w-1:0] fill_idx,
	output logic [dcache_pkg::tag_w-1:0] fill_tag,
	output logic line_set,
	output logic line_clr,
	output logic rw_wait,
	output logic [31:0] rd_data
);
	logic [credit_w-1:0] credits;
	logic credit_ok;
	logic cacheable;
	logic start_read;
	logic start_write;
	logic fill_pending;
	logic clr_pending;
	logic done_s1;
	logic done_s2;

	assign credit_ok = (credits != '0);
	assign cacheable = !core.addr[31];
	// one fill at a time
	assign start_read = core.rd && cacheable && !hit && !fill_pending && credit_ok;
	assign start_write = core.wr && cacheable && credit_ok;

	// valid bit drops the cycle after the request, once fill_idx is loaded
	assign line_clr = clr_pending;
	// fill side has echoed our toggle back
	assign line_set = fill_pending && (done_s2 == rd_tog);

	always_comb begin
		fsabo = '0;
		if (start_read) begin
			fsabo.valid = 1'b1;
			fsabo.mode = dcache_pkg::fsab_read;
			fsabo.did = dcache_pkg::fsab_did_cpu;
			fsabo.subdid = dcache_pkg::fsab_subdid_dcache;
			fsabo.addr = {core.addr[30:6], 6'b0};
			fsabo.len = 4'(dcache_pkg::fsab_len_line);
		end else if (start_write) begin
			// one 8-byte beat, mask picks the half
			fsabo.valid = 1'b1;
			fsabo.mode = dcache_pkg::fsab_write;
			fsabo.did = dcache_pkg::fsab_did_cpu;
			fsabo.subdid = dcache_pkg::fsab_subdid_dcache;
			fsabo.addr = {core.addr[30:3], 3'b0};
			fsabo.len = 4'(dcache_pkg::fsab_len_word);
			fsabo.data = {core.wdata, core.wdata};
			fsabo.mask = core.addr[2] ? 8'hf0 : 8'h0f;
		end
	end

	// every request is one cycle, so one credit each
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= credit_w'(init_credits);
		end else begin
			credits <= credits + credit_w'(fsabo_credit) - credit_w'(fsabo.valid);
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			fill_pending <= 1'b0;
			clr_pending <= 1'b0;
			rd_tog <= 1'b0;
			done_s1 <= 1'b0;
			done_s2 <= 1'b0;
		end else begin
			// two-flop sync of the fill done toggle
			done_s1 <= done_tog;
			done_s2 <= done_s1;
			clr_pending <= start_read;
			if (start_read) begin
				fill_pending <= 1'b1;
				rd_tog <= ~rd_tog;
			end else if (line_set) begin
				fill_pending <= 1'b0;
			end
		end
	end

	// fill address frozen until line_set for the array fill port
	always_ff @(posedge clk) begin
		if (start_read) begin
			fill_idx <= core.addr[9:6];
			fill_tag <= core.addr[31 -: dcache_pkg::tag_w];
		end
	end

	always_comb begin
		if (cacheable) begin
			// miss waits for the refill, write waits for a credit
			rw_wait = (core.rd && !hit) || (core.wr && !credit_ok);
			rd_data = rd_word;
		end else begin
			rw_wait = wait_spam;
			rd_data = rd_data_spam;
		end
	end

	// count stays within 0..init_credits and never wraps
	a_credit_range: assert property (@(posedge clk) disable iff (!rst_b)
		credits <= credit_w'(init_credits));

endmodule

`default_nettype wire

/* src/dcache_top.sv */
// data cache subsystem top; connect the core port, the FSAB buses and the SPAM side channel
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int init_credits = 4,
	parameter int credit_w = 3,
	parameter int spam_timeout = dcache_pkg::spam_timeout_init
) (
	input wire logic clk,
	input wire logic rst_b,
	input wire logic fsabi_clk,
	input wire logic fsabi_rst_b,
	input wire dcache_pkg::core_req_t core,
	output logic rw_wait,
	output logic [31:0] rd_data,
	output dcache_pkg::fsab_req_t fsabo,
	input wire logic fsabo_credit,
	input wire dcache_pkg::fsab_resp_t fsabi,
	output dcache_pkg::spam_req_t spamo,
	input wire logic spami_busy_b,
	input wire logic [31:0] spami_data
);
	// lookup results
	logic hit;
	logic [31:0] rd_word;
	// fill handshake across the clock domains
	logic rd_tog;
	logic done_tog;
	// array line and fill ports
	logic [dcache_pkg::idx_w-1:0] fill_idx;
	logic [dcache_pkg::tag_w-1:0] fill_tag;
	logic line_set;
	logic line_clr;
	logic fill_we;
	logic [dcache_pkg::word_w-1:0] fill_word;
	logic [63:0] fill_data;
	// side channel result
	logic wait_spam;
	logic [31:0] rd_data_spam;

	dcache_array i_dcache_array (
		.clk(clk),
		.rst_b(rst_b),
		.lookup_addr(core.addr),
		.core_wr(core.wr),
		.core_wdata(core.wdata),
		.fill_idx(fill_idx),
		.line_set(line_set),
		.line_clr(line_clr),
		.fill_tag(fill_tag),
		.fill_we(fill_we),
		.fill_word(fill_word),
		.fill_data(fill_data),
		.hit(hit),
		.rd_word(rd_word)
	);

	dcache_fill i_dcache_fill (
		.fsabi_clk(fsabi_clk),
		.fsabi_rst_b(fsabi_rst_b),
		.fsabi(fsabi),
		.rd_tog(rd_tog),
		.done_tog(done_tog),
		.fill_we(fill_we),
		.fill_word(fill_word),
		.fill_data(fill_data)
	);

	spam_initiator #(
		.spam_timeout(spam_timeout)
	) i_spam_initiator (
		.clk(clk),
		.rst_b(rst_b),
		.core(core),
		.spami_busy_b(spami_busy_b),
		.spami_data(spami_data),
		.spamo(spamo),
		.wait_spam(wait_spam),
		.rd_data_spam(rd_data_spam)
	);

	dcache_ctrl #(
		.init_credits(init_credits),
		.credit_w(credit_w)
	) i_dcache_ctrl (
		.clk(clk),
		.rst_b(rst_b),
		.core(core),
		.hit(hit),
		.rd_word(rd_word),
		.fsabo_credit(fsabo_credit),
		.done_tog(done_tog),
		.wait_spam(wait_spam),
		.rd_data_spam(rd_data_spam),
		.fsabo(fsabo),
		.rd_tog(rd_tog),
		.fill_idx(fill_idx),
		.fill_tag(fill_tag),
		.line_set(line_set),
		.line_clr(line_clr),
		.rw_wait(rw_wait),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

/* sim/tb_fsab_mem.sv */
// testbench FSAB memory model; returns credits, answers line reads on fsabi_clk, applies writes
`timescale 1ns/1ps
`default_nettype none

module tb_fsab_mem (
	input wire logic clk,
	input wire logic rst_b,
	input wire logic fsabi_clk,
	input wire dcache_pkg::fsab_req_t fsabo,
	input wire logic hold_credits,
	output logic fsabo_credit,
	output dcache_pkg::fsab_resp_t fsabi,
	output logic rule_err
);
	localparam int mem_words = 8192;

	// first 32 KB are stored, everything above reads the default pattern
	logic [31:0] words [0:mem_words-1];
	logic [30:0] read_q [$];
	int credit_due [$];
	int cycle;
	int req_cnt;
	logic [30:0] line_addr;
	logic [31:0] base;
	dcache_pkg::fsab_resp_t beat_resp;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		if (addr[31:15] == '0) begin
			return words[addr[14:2]];
		end
		return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	task automatic flag_rule(input string what);
		$display("fsab memory model at %0t: %s", $time, what);
		rule_err <= 1'b1;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] be);
		logic [31:0] merged;
		merged = word_at(addr);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				merged[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		if (addr[31:15] != '0) begin
			flag_rule("write above the modelled range");
		end else begin
			words[addr[14:2]] = merged;
		end
	endtask

	// request side, bus rules and credit return
	always @(posedge clk) begin
		if (!rst_b) begin
			cycle = 0;
			req_cnt = 0;
			credit_due.delete();
			fsabo_credit <= 1'b0;
		end else begin
			cycle++;
			if (fsabo.valid) begin
				if (fsabo.did !== dcache_pkg::fsab_did_cpu ||
						fsabo.subdid !== dcache_pkg::fsab_subdid_dcache) begin
					flag_rule("request carries a wrong did or subdid");
				end
				if (fsabo.mode == dcache_pkg::fsab_read) begin
					if (fsabo.len !== 4'd8 || fsabo.addr[5:0] !== 6'd0) begin
						flag_rule("line read with bad length or alignment");
					end
					read_q.push_back(fsabo.addr);
				end else begin
					if (fsabo.len !== 4'd1 || fsabo.addr[2:0] !== 3'd0) begin
						flag_rule("write with bad length or alignment");
					end
					if (fsabo.data[63:32] !== fsabo.data[31:0]) begin
						flag_rule("write data halves differ");
					end
					if (fsabo.mask !== 8'h0f && fsabo.mask !== 8'hf0) begin
						flag_rule("write mask is not one word half");
					end
					write_word({1'b0, fsabo.addr}, fsabo.data[31:0], fsabo.mask[3:0]);
					write_word({1'b0, fsabo.addr} + 32'd4, fsabo.data[63:32], fsabo.mask[7:4]);
				end
				// credit back after 3 to 6 cycles
				credit_due.push_back(cycle + 3 + (req_cnt % 4));
				req_cnt++;
			end
			if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
				fsabo_credit <= 1'b1;
				credit_due.delete(0);
			end else begin
				fsabo_credit <= 1'b0;
			end
		end
	end

	// inbound side, 8 beats after 4 fsabi cycles
	initial begin
		fsabi = '0;
		fsabo_credit = 1'b0;
		rule_err = 1'b0;
		for (int i = 0; i < mem_words; i++) begin
			words[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
		end
		forever begin
			@(posedge fsabi_clk);
			if (read_q.size() > 0) begin
				line_addr = read_q.pop_front();
				repeat (4) @(posedge fsabi_clk);
				for (int beat = 0; beat < 8; beat++) begin
					base = {1'b0, line_addr} + 32'(beat * 8);
					beat_resp.valid = 1'b1;
					beat_resp.did = dcache_pkg::fsab_did_cpu;
					beat_resp.subdid = dcache_pkg::fsab_subdid_dcache;
					beat_resp.data = {word_at(base + 32'd4), word_at(base)};
					fsabi <= beat_resp;
					@(posedge fsabi_clk);
				end
				fsabi <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_dcache_top.sv */
// data cache subsystem testbench; runs the operations of sim/dcache_vectors.txt through the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;
	localparam int vec_max = 256;
	localparam int ref_size = 8192;

	logic clk;
	logic fsabi_clk;
	logic rst_b;
	logic fsabi_rst_b;
	dcache_pkg::core_req_t core;
	logic rw_wait;
	logic [31:0] rd_data;
	dcache_pkg::fsab_req_t fsabo;
	logic fsabo_credit;
	dcache_pkg::fsab_resp_t fsabi;
	dcache_pkg::spam_req_t spamo;
	logic spami_busy_b = 1'b1;
	logic [31:0] spami_data = '0;
	logic hold_credits = 1'b0;
	logic rule_err;

	// four words per vector
	logic [31:0] vec_words [0:vec_max*4-1];
	logic [31:0] ref_mem [0:ref_size-1];
	// lines the cache should hold
	logic [15:0] exp_vld = '0;
	logic [21:0] exp_tag [0:15];
	int vec_idx;
	logic credits_held = 1'b0;

	// traffic seen on fsabo and spamo
	int rd_reqs = 0;
	int wr_reqs = 0;
	int spam_reqs = 0;
	logic [30:0] last_rd_addr;
	dcache_pkg::fsab_req_t last_wr;
	dcache_pkg::spam_req_t last_spam;

	// spam responder
	logic no_response = 1'b0;
	logic spam_hang;
	int spam_left;
	logic [31:0] spam_reply;
	logic [31:0] lcg_state = 32'h8d6f_00ce;

	dcache_top #(
		.init_credits(4),
		.credit_w(3),
		.spam_timeout(255)
	) i_dcache_top (
		.clk(clk),
		.rst_b(rst_b),
		.fsabi_clk(fsabi_clk),
		.fsabi_rst_b(fsabi_rst_b),
		.core(core),
		.rw_wait(rw_wait),
		.rd_data(rd_data),
		.fsabo(fsabo),
		.fsabo_credit(fsabo_credit),
		.fsabi(fsabi),
		.spamo(spamo),
		.spami_busy_b(spami_busy_b),
		.spami_data(spami_data)
	);

	tb_fsab_mem i_fsab_mem (
		.clk(clk),
		.rst_b(rst_b),
		.fsabi_clk(fsabi_clk),
		.fsabo(fsabo),
		.hold_credits(hold_credits),
		.fsabo_credit(fsabo_credit),
		.fsabi(fsabi),
		.rule_err(rule_err)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		fsabi_clk = 1'b0;
		forever #3 fsabi_clk = ~fsabi_clk;
	end

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {16'h0, lcg_state[31:16]};
	endfunction

	function automatic logic [31:0] ref_word(input logic [31:0] addr);
		if (addr[31:15] == '0) begin
			return ref_mem[addr[14:2]];
		end
		return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic compare_val(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
				$time, name, got, exp));
		end
	endtask

	task automatic start_access(input logic rd, input logic wr, input logic [31:0] addr,
			input logic [31:0] wdata);
		dcache_pkg::core_req_t req;
		req.rd = rd;
		req.wr = wr;
		req.addr = addr;
		req.wdata = wdata;
		@(posedge clk);
		core <= req;
	endtask

	// waits for rw_wait low, takes rd_data in that cycle
	task automatic finish_access(input int limit, output logic [31:0] data, output int waited);
		waited = 0;
		@(negedge clk);
		while (rw_wait) begin
			if (waited >= limit) begin
				abort_run($sformatf("timeout at %0t, rw_wait stayed high for %0d cycles",
					$time, limit));
			end
			waited++;
			@(negedge clk);
		end
		data = rd_data;
		@(posedge clk);
		core <= '0;
		@(negedge clk);
	endtask

	task automatic check_read(input logic [31:0] addr);
		logic [31:0] got;
		int waited;
		int rd_before;
		logic [3:0] line;
		logic hit_exp;
		line = addr[9:6];
		hit_exp = exp_vld[line] && (exp_tag[line] == addr[31:10]);
		rd_before = rd_reqs;
		start_access(1'b1, 1'b0, addr, '0);
		finish_access(200, got, waited);
		compare_val("rd_data", got, ref_word(addr));
		compare_val("fsab line reads", rd_reqs - rd_before, hit_exp ? 0 : 1);
		if (hit_exp) begin
			compare_val("read hit wait cycles", waited, 0);
		end else begin
			compare_val("fsabo.addr", last_rd_addr, {addr[30:6], 6'b0});
		end
		exp_vld[line] = 1'b1;
		exp_tag[line] = addr[31:10];
	endtask

	// one write on fsab, data twice, mask from bit 2
	task automatic write_checks(input logic [31:0] addr, input logic [31:0] wdata,
			input int wr_before);
		compare_val("fsab writes", wr_reqs - wr_before, 1);
		compare_val("fsabo.addr", last_wr.addr, {addr[30:3], 3'b0});
		compare_val("fsabo.data", last_wr.data, {wdata, wdata});
		compare_val("fsabo.mask", last_wr.mask, addr[2] ? 8'hf0 : 8'h0f);
		if (addr[31:15] != '0) begin
			abort_run("vector writes above the modelled memory range");
		end
		ref_mem[addr[14:2]] = wdata;
	endtask

	task automatic check_write(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] got;
		int waited;
		int wr_before;
		wr_before = wr_reqs;
		start_access(1'b0, 1'b1, addr, wdata);
		finish_access(200, got, waited);
		// with credits left the write goes out at once
		if (credits_held) begin
			compare_val("write wait cycles", waited, 0);
		end
		write_checks(addr, wdata, wr_before);
	endtask

	task automatic stall_write(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] got;
		int waited;
		int wr_before;
		wr_before = wr_reqs;
		start_access(1'b0, 1'b1, addr, wdata);
		for (int i = 0; i < 12; i++) begin
			@(negedge clk);
			compare_val("rw_wait", rw_wait, 1'b1);
		end
		compare_val("fsab writes while out of credits", wr_reqs - wr_before, 0);
		@(posedge clk);
		hold_credits <= 1'b0;
		credits_held = 1'b0;
		finish_access(100, got, waited);
		write_checks(addr, wdata, wr_before);
	endtask

	task automatic check_spam(input logic rd, input logic hang, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] exp);
		logic [31:0] got;
		int waited;
		int spam_before;
		int fsab_before;
		spam_before = spam_reqs;
		fsab_before = rd_reqs + wr_reqs;
		no_response = hang;
		start_access(rd, !rd, addr, wdata);
		finish_access(hang ? 400 : 100, got, waited);
		no_response = 1'b0;
		compare_val("spam requests", spam_reqs - spam_before, 1);
		compare_val("fsab requests for spam", rd_reqs + wr_reqs - fsab_before, 0);
		compare_val("spamo.r_nw", last_spam.r_nw, rd);
		compare_val("spamo.did", last_spam.did, addr[27:24]);
		compare_val("spamo.addr", last_spam.addr, addr[23:0]);
		if (rd) begin
			compare_val("rd_data", got, exp);
		end else begin
			compare_val("spamo.data", last_spam.data, wdata);
		end
	endtask

	// op codes as listed at the top of the vector file
	task automatic run_vector(input logic [31:0] op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] exp);
		case (op)
			32'd0: check_read(addr);
			32'd1: check_write(addr, wdata);
			32'd2: check_spam(1'b1, 1'b0, addr, wdata, exp);
			32'd3: check_spam(1'b0, 1'b0, addr, wdata, exp);
			32'd4: check_spam(1'b1, 1'b1, addr, wdata, exp);
			32'd5: begin
				// let outstanding credits come home first
				repeat (20) @(posedge clk);
				hold_credits <= 1'b1;
				credits_held = 1'b1;
			end
			32'd6: stall_write(addr, wdata);
			default: abort_run($sformatf("unknown op %0h in vector %0d", op, vec_idx));
		endcase
	endtask

	// request monitor
	always @(posedge clk) begin
		if (rst_b && fsabo.valid) begin
			if (fsabo.mode == dcache_pkg::fsab_read) begin
				rd_reqs++;
				last_rd_addr = fsabo.addr;
			end else begin
				wr_reqs++;
				last_wr = fsabo;
			end
		end
		if (rule_err === 1'b1) begin
			abort_run("FSAB memory model saw a request that breaks the bus rules");
		end
	end

	// spam responder, busy for 1 to 20 cycles
	always @(posedge clk) begin
		if (!rst_b) begin
			spami_busy_b <= 1'b1;
		end else if (spamo.valid) begin
			spam_reqs++;
			last_spam = spamo;
			spami_busy_b <= 1'b0;
			spam_left = 1 + (next_rand() % 20);
			spam_reply <= {4'h8, spamo.did, spamo.addr} ^ 32'hc0de_0000;
			spam_hang <= no_response;
		end else if (!spami_busy_b) begin
			if (spam_hang) begin
				// silent peripheral lets go once that vector is over
				if (!no_response) begin
					spami_busy_b <= 1'b1;
				end
			end else if (spam_left > 1) begin
				spam_left--;
			end else begin
				spami_busy_b <= 1'b1;
				spami_data <= spam_reply;
			end
		end
	end

	initial begin
		core = '0;
		rst_b = 1'b0;
		fsabi_rst_b = 1'b0;
		for (int i = 0; i < ref_size; i++) begin
			ref_mem[i] = (32'(i) << 2) ^ 32'h5a5a_0000;
		end
		$readmemh("sim/dcache_vectors.txt", vec_words);
		repeat (8) @(posedge clk);
		rst_b <= 1'b1;
		fsabi_rst_b <= 1'b1;
		@(negedge clk);
		compare_val("fsabo.valid", fsabo.valid, 1'b0);
		compare_val("spamo.valid", spamo.valid, 1'b0);
		vec_idx = 0;
		while (vec_words[vec_idx*4] !== 32'hf) begin
			if (vec_idx >= vec_max - 1) begin
				abort_run("vector file has no end marker");
			end
			run_vector(vec_words[vec_idx*4], vec_words[vec_idx*4+1],
				vec_words[vec_idx*4+2], vec_words[vec_idx*4+3]);
			vec_idx++;
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
src/dcache_pkg.sv
src/dcache_array.sv
src/dcache_fill.sv
src/spam_initiator.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/tb_fsab_mem.sv
sim/tb_dcache_top.sv

/* Bender.yml */
package:
  name: dcache_subsystem

sources:
  - src/dcache_pkg.sv
  - src/dcache_array.sv
  - src/dcache_fill.sv
  - src/spam_initiator.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: simulation
    files:
      - sim/tb_fsab_mem.sv
      - sim/tb_dcache_top.sv

/* sim/dcache_vectors.txt */
// each line holds op address wdata expected (expected is used by spam reads only)
// op 0 read 1 write 2 spam read 3 spam write 4 spam read no response 5 hold credits 6 stalled write f end
0 00001040 00000000 00000000
0 00001044 00000000 00000000
0 0000107c 00000000 00000000
0 00005040 00000000 00000000
0 00001048 00000000 00000000
1 00001050 12345678 00000000
0 00001050 00000000 00000000
1 00002004 cafef00d 00000000
0 00002004 00000000 00000000
0 00002000 00000000 00000000
2 81123450 00000000 41cc3450
3 8a00beef 0badc0de 00000000
2 83000010 00000000 43de0010
4 85000020 00000000 deaddead
2 81000004 00000000 41de0004
5 00000000 00000000 00000000
1 00003000 11111111 00000000
1 00003008 22222222 00000000
1 0000300c 33333333 00000000
1 00003010 44444444 00000000
6 00003014 55555555 00000000
0 00003014 00000000 00000000
0 0000300c 00000000 00000000
0 00002004 00000000 00000000
f 00000000 00000000 00000000
